// ==== Bender.yml ====
package:
  name: nand_read_page

sources:
  # packages first, then the engine
  - src/nandGeomPkg.sv
  - src/nandCmdPkg.sv
  - src/readCommandRegs.sv
  - src/readPageSequencer.sv
  - src/nandReadPage.sv

  # testbench with its primitive generator model
  - target: test
    files:
      - tb/acgResponder.sv
      - tb/nandReadPageTb.sv

// ==== files.f ====
src/nandGeomPkg.sv
src/nandCmdPkg.sv
src/readCommandRegs.sv
src/readPageSequencer.sv
src/nandReadPage.sv
tb/acgResponder.sv
tb/nandReadPageTb.sv

// ==== src/nandCmdPkg.sv ====
`default_nettype none

package nandCmdPkg;

    // opcode this engine answers to
    localparam logic [5:0] readPageOpcode = 6'b000100;

    // bits of the primitive select vector and of the last-step vector
    localparam int primCmdAddrBit = 3;
    localparam int primDataInBit = 1;

    // page read opcode pair
    localparam logic [7:0] nandReadCmd1 = 8'h00;
    localparam logic [7:0] nandReadCmd2 = 8'h30;

    // counted from zero, so five address cycles
    localparam int addrCycleCount = 4;

    // phase codes, also used as bit index of the one-hot state
    localparam int phaseWidth = 3;

    localparam logic [phaseWidth-1:0] phaseIdle = 3'd0;
    localparam logic [phaseWidth-1:0] phaseLatch = 3'd1;
    localparam logic [phaseWidth-1:0] phaseCmd1 = 3'd2;
    localparam logic [phaseWidth-1:0] phaseAddr = 3'd3;
    localparam logic [phaseWidth-1:0] phaseCmd2 = 3'd4;
    // flash busy after 30h, wait for R/B low then high
    localparam logic [phaseWidth-1:0] phaseWaitBusy = 3'd5;
    localparam logic [phaseWidth-1:0] phaseWaitReady = 3'd6;
    localparam logic [phaseWidth-1:0] phaseData = 3'd7;

endpackage

`default_nettype wire

// ==== src/nandGeomPkg.sv ====
`default_nettype none

package nandGeomPkg;

    // one chip enable and one ready/busy line per way
    localparam int numWays = 4;

    localparam int colAddrWidth = 16;
    localparam int rowAddrWidth = 24;
    localparam int lengthWidth = 16;

    // flash bus is a byte wide
    localparam int byteWidth = 8;
    localparam int caWordWidth = 40;

    localparam int opcodeWidth = 6;
    localparam int primSelWidth = 8;

    // five address cycles, first byte out sits in the top slot
    typedef struct packed {
        logic [byteWidth-1:0] colLow;
        logic [byteWidth-1:0] colHigh;
        logic [byteWidth-1:0] rowLow;
        logic [byteWidth-1:0] rowMid;
        logic [byteWidth-1:0] rowHigh;
    } caAddrViewT;

    // single command cycle, byte on top
    typedef struct packed {
        logic [byteWidth-1:0] command;
        logic [caWordWidth-byteWidth-1:0] pad;
    } caCmdViewT;

    // same word, read as address cycles or as a command byte
    typedef union packed {
        caAddrViewT addr;
        caCmdViewT cmd;
    } caWordT;

endpackage

`default_nettype wire

// ==== src/nandReadPage.sv ====
`timescale 1ns/1ps
`default_nettype none

module nandReadPage
    import nandGeomPkg::*, nandCmdPkg::*;
(
    input  wire logic                    iSystemClock,
    input  wire logic                    arstN,

    // host command port
    input  wire logic [opcodeWidth-1:0]  opcode,
    input  wire logic                    cmdValid,
    output logic                         cmdReady,
    output logic                         start,
    input  wire logic [numWays-1:0]      waySelect,
    input  wire logic [colAddrWidth-1:0] colAddress,
    input  wire logic [rowAddrWidth-1:0] rowAddress,
    input  wire logic [lengthWidth-1:0]  length,
    output logic                         transValid,
    output logic                         lastStep,

    // primitive generator side
    output logic      [primSelWidth-1:0] acgCommand,
    output logic      [numWays-1:0]      acgTargetWay,
    output logic      [lengthWidth-1:0]  acgNumOfData,
    output logic                         acgCaSelect,
    output caWordT                       acgCaData,
    input  wire logic [primSelWidth-1:0] acgLastStep,
    input  wire logic [numWays-1:0]      acgReadyBusy
);

    logic                  accept;
    logic [phaseWidth-1:0] phase;

    readPageSequencer sequencer (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .opcode       (opcode),
        .cmdValid     (cmdValid),
        .targetWay    (acgTargetWay),
        .acgLastStep  (acgLastStep),
        .acgReadyBusy (acgReadyBusy),
        .start        (start),
        .cmdReady     (cmdReady),
        .accept       (accept),
        .phase        (phase),
        .acgCommand   (acgCommand),
        .transValid   (transValid),
        .lastStep     (lastStep)
    );

    // latched request and the word for each phase
    readCommandRegs commandRegs (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .accept       (accept),
        .phase        (phase),
        .waySelect    (waySelect),
        .colAddress   (colAddress),
        .rowAddress   (rowAddress),
        .length       (length),
        .targetWay    (acgTargetWay),
        .acgNumOfData (acgNumOfData),
        .acgCaSelect  (acgCaSelect),
        .acgCaData    (acgCaData)
    );

endmodule

`default_nettype wire

// ==== src/readCommandRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module readCommandRegs
    import nandGeomPkg::*, nandCmdPkg::*;
(
    input  wire logic                    iSystemClock,
    input  wire logic                    arstN,
    input  wire logic                    accept,
    input  wire logic [phaseWidth-1:0]   phase,
    input  wire logic [numWays-1:0]      waySelect,
    input  wire logic [colAddrWidth-1:0] colAddress,
    input  wire logic [rowAddrWidth-1:0] rowAddress,
    input  wire logic [lengthWidth-1:0]  length,
    output logic      [numWays-1:0]      targetWay,
    output logic      [lengthWidth-1:0]  acgNumOfData,
    output logic                         acgCaSelect,
    output caWordT                       acgCaData
);

    logic [colAddrWidth-1:0] colQ;
    logic [rowAddrWidth-1:0] rowQ;
    logic [lengthWidth-1:0]  lengthQ;

    caWordT                  nextWord;
    logic                    nextSelect;
    logic [lengthWidth-1:0]  nextCount;

    // request payload, captured once per command
    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            colQ <= '0;
            rowQ <= '0;
            lengthQ <= '0;
        end else if (accept) begin
            colQ <= colAddress;
            rowQ <= rowAddress;
            lengthQ <= length;
        end
    end

    // chip enables are active low
    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            targetWay <= '0;
        end else if (phase == phaseIdle || accept) begin
            targetWay <= ~waySelect;
        end
    end

    // phase is the upcoming one, so the word lands with the new state
    always_comb begin
        nextWord = '0;
        nextSelect = 1'b1;
        nextCount = '0;
        case (phase)
            phaseCmd1: begin
                nextWord.cmd.command = nandReadCmd1;
            end
            phaseAddr: begin
                nextSelect = 1'b0;
                nextCount = lengthWidth'(addrCycleCount);
                // column first, low byte before high byte
                nextWord.addr.colLow = colQ[7:0];
                nextWord.addr.colHigh = colQ[15:8];
                nextWord.addr.rowLow = rowQ[7:0];
                nextWord.addr.rowMid = rowQ[15:8];
                nextWord.addr.rowHigh = rowQ[23:16];
            end
            phaseCmd2: begin
                nextWord.cmd.command = nandReadCmd2;
            end
            phaseData: begin
                nextSelect = 1'b0;
                nextCount = lengthQ;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            acgNumOfData <= '0;
            acgCaSelect <= 1'b1;
            acgCaData <= '0;
        end else begin
            acgNumOfData <= nextCount;
            acgCaSelect <= nextSelect;
            acgCaData <= nextWord;
        end
    end

endmodule

`default_nettype wire

// ==== src/readPageSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module readPageSequencer
    import nandGeomPkg::*, nandCmdPkg::*;
(
    input  wire logic                    iSystemClock,
    input  wire logic                    arstN,
    input  wire logic [opcodeWidth-1:0]  opcode,
    input  wire logic                    cmdValid,
    input  wire logic [numWays-1:0]      targetWay,
    input  wire logic [primSelWidth-1:0] acgLastStep,
    input  wire logic [numWays-1:0]      acgReadyBusy,
    output logic                         start,
    output logic                         cmdReady,
    output logic                         accept,
    output logic      [phaseWidth-1:0]   phase,
    output logic      [primSelWidth-1:0] acgCommand,
    output logic                         transValid,
    output logic                         lastStep
);

    // one bit per phase code
    logic [(1 << phaseWidth)-1:0] stateQ;

    logic [numWays-1:0]      rbMasked;
    logic                    wayReady;
    logic [primSelWidth-1:0] nextCommand;

    logic cmdAddrDone;
    logic dataInDone;

    // request for this engine, whether or not it can take it now
    assign start = (opcode == readPageOpcode) && cmdValid;
    assign accept = start && cmdReady;

    assign cmdAddrDone = acgLastStep[primCmdAddrBit];
    assign dataInDone = acgLastStep[primDataInBit];

    // phase carries the next state; every registered output follows it
    always_comb begin
        phase = phaseIdle;
        case (1'b1)
            stateQ[phaseIdle]: begin
                phase = accept ? phaseLatch : phaseIdle;
            end
            stateQ[phaseLatch]: begin
                phase = phaseCmd1;
            end
            stateQ[phaseCmd1]: begin
                phase = cmdAddrDone ? phaseAddr : phaseCmd1;
            end
            stateQ[phaseAddr]: begin
                phase = cmdAddrDone ? phaseCmd2 : phaseAddr;
            end
            stateQ[phaseCmd2]: begin
                phase = cmdAddrDone ? phaseWaitBusy : phaseCmd2;
            end
            stateQ[phaseWaitBusy]: begin
                phase = wayReady ? phaseWaitBusy : phaseWaitReady;
            end
            stateQ[phaseWaitReady]: begin
                phase = wayReady ? phaseData : phaseWaitReady;
            end
            stateQ[phaseData]: begin
                // leave one cycle after the done pulse
                phase = lastStep ? phaseIdle : phaseData;
            end
            default: begin
                phase = phaseIdle;
            end
        endcase
    end

    // primitive select for the coming phase
    always_comb begin
        nextCommand = '0;
        case (phase)
            phaseCmd1, phaseAddr, phaseCmd2: begin
                nextCommand[primCmdAddrBit] = 1'b1;
            end
            phaseData: begin
                // drop the select as soon as the transfer reports done
                nextCommand[primDataInBit] = !dataInDone;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            stateQ <= '0;
            stateQ[phaseIdle] <= 1'b1;
            cmdReady <= 1'b1;
            acgCommand <= '0;
            transValid <= 1'b0;
            lastStep <= 1'b0;
        end else begin
            stateQ <= '0;
            stateQ[phase] <= 1'b1;
            cmdReady <= (phase == phaseIdle);
            acgCommand <= nextCommand;
            // single pulse on entry into the data phase
            transValid <= (phase == phaseData) && stateQ[phaseWaitReady];
            lastStep <= (phase == phaseData) && dataInDone;
        end
    end

    // ready/busy of the selected ways, two register stages
    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            rbMasked <= '0;
            wayReady <= 1'b0;
        end else begin
            rbMasked <= ~targetWay & acgReadyBusy;
            wayReady <= |rbMasked;
        end
    end

endmodule

`default_nettype wire

// ==== tb/acgResponder.sv ====
`timescale 1ns/1ps
`default_nettype none

module acgResponder
    import nandGeomPkg::*, nandCmdPkg::*;
(
    input  wire logic                    iSystemClock,
    input  wire logic                    arstN,
    input  wire logic [primSelWidth-1:0] acgCommand,
    input  wire logic [numWays-1:0]      acgTargetWay,
    input  wire logic                    acgCaSelect,
    input  wire caWordT                  acgCaData,
    output logic      [primSelWidth-1:0] acgLastStep,
    output logic      [numWays-1:0]      acgReadyBusy
);

    initial begin : respond
        logic [primSelWidth-1:0] selected;
        logic [numWays-1:0]      ways;
        logic                    confirmPhase;
        int                      delay;
        int                      busyCycles;

        acgLastStep = '0;
        acgReadyBusy = '1;
        wait (arstN === 1'b1);
        forever begin
            // sample the select away from the active edge
            @(negedge iSystemClock);
            if (acgCommand[primCmdAddrBit] || acgCommand[primDataInBit]) begin
                selected = acgCommand;
                ways = ~acgTargetWay;
                confirmPhase = acgCaSelect && (acgCaData.cmd.command == nandReadCmd2);
                delay = $urandom_range(8, 1);
                repeat (delay) @(posedge iSystemClock);
                acgLastStep <= selected;
                @(posedge iSystemClock);
                acgLastStep <= '0;
                if (confirmPhase) begin
                    // unselected ways go busy first, the engine must keep waiting
                    if (ways != '1) begin
                        acgReadyBusy <= ways;
                        repeat (3) @(posedge iSystemClock);
                        acgReadyBusy <= '1;
                    end
                    // selected ways busy while the page loads
                    busyCycles = $urandom_range(20, 4);
                    @(posedge iSystemClock);
                    acgReadyBusy <= ~ways;
                    repeat (busyCycles) @(posedge iSystemClock);
                    acgReadyBusy <= '1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/nandReadPageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module nandReadPageTb
    import nandGeomPkg::*, nandCmdPkg::*;
();

    localparam int clockPeriod = 40;
    localparam int resetCycles = 16;
    localparam int commandCount = 6;
    localparam int testCount = commandCount + 2;
    // one read page runs about 75 cycles at the longest responder delays
    localparam int cyclesPerTest = 100;
    localparam int watchdogCycles = resetCycles + testCount * cyclesPerTest + 50;

    logic                    iSystemClock;
    logic                    arstN;
    logic [opcodeWidth-1:0]  opcode;
    logic                    cmdValid;
    logic                    cmdReady;
    logic                    start;
    logic [numWays-1:0]      waySelect;
    logic [colAddrWidth-1:0] colAddress;
    logic [rowAddrWidth-1:0] rowAddress;
    logic [lengthWidth-1:0]  length;
    logic                    transValid;
    logic                    lastStep;
    logic [primSelWidth-1:0] acgCommand;
    logic [numWays-1:0]      acgTargetWay;
    logic [lengthWidth-1:0]  acgNumOfData;
    logic                    acgCaSelect;
    caWordT                  acgCaData;
    logic [primSelWidth-1:0] acgLastStep;
    logic [numWays-1:0]      acgReadyBusy;

    int    errorCount;
    int    testErrors;
    int    cleanTests;
    string testName;
    // selected ways seen low, then high again
    logic  busySeen;
    logic  releaseSeen;

    nandReadPage UUT (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .opcode       (opcode),
        .cmdValid     (cmdValid),
        .cmdReady     (cmdReady),
        .start        (start),
        .waySelect    (waySelect),
        .colAddress   (colAddress),
        .rowAddress   (rowAddress),
        .length       (length),
        .transValid   (transValid),
        .lastStep     (lastStep),
        .acgCommand   (acgCommand),
        .acgTargetWay (acgTargetWay),
        .acgNumOfData (acgNumOfData),
        .acgCaSelect  (acgCaSelect),
        .acgCaData    (acgCaData),
        .acgLastStep  (acgLastStep),
        .acgReadyBusy (acgReadyBusy)
    );

    acgResponder responder (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .acgCommand   (acgCommand),
        .acgTargetWay (acgTargetWay),
        .acgCaSelect  (acgCaSelect),
        .acgCaData    (acgCaData),
        .acgLastStep  (acgLastStep),
        .acgReadyBusy (acgReadyBusy)
    );

    always #(clockPeriod / 2) iSystemClock = ~iSystemClock;

    task automatic reportViolation(input string what);
        errorCount++;
        testErrors++;
        $display("[FAIL] %s: %s", testName, what);
    endtask

    task automatic compareValue(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
        assert (actual === expected) else begin
            errorCount++;
            testErrors++;
            $display("[FAIL] %s: %s expected %0h actual %0h", testName, what, expected, actual);
        end
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            $display("test %s: ok", testName);
            cleanTests++;
        end else begin
            $display("test %s: %0d errors", testName, testErrors);
        end
        testErrors = 0;
    endtask

    // five address cycles, column low byte goes out first
    function automatic logic [caWordWidth-1:0] addressWord(input logic [15:0] col,
                                                           input logic [23:0] row);
        return {col[7:0], col[15:8], row[7:0], row[15:8], row[23:16]};
    endfunction

    always @(negedge iSystemClock) begin
        if (!arstN || cmdReady) begin
            busySeen <= 1'b0;
            releaseSeen <= 1'b0;
        end else if ((acgReadyBusy & ~acgTargetWay) == '0) begin
            busySeen <= 1'b1;
        end else if (busySeen) begin
            releaseSeen <= 1'b1;
        end
    end

    transValidSingle: assert property (@(posedge iSystemClock) disable iff (!arstN)
        transValid |=> !transValid)
        else reportViolation("transValid stayed high for more than one cycle");

    lastStepSingle: assert property (@(posedge iSystemClock) disable iff (!arstN)
        lastStep |=> (!lastStep && cmdReady))
        else reportViolation("lastStep was not a single pulse followed by cmdReady");

    dataDoneDropsSelect: assert property (@(posedge iSystemClock) disable iff (!arstN)
        (acgCommand[primDataInBit] && acgLastStep[primDataInBit])
        |=> (lastStep && acgCommand == '0))
        else reportViolation("data-in select or lastStep wrong after the transfer ended");

    oneSelect: assert property (@(posedge iSystemClock) disable iff (!arstN)
        !(acgCommand[primCmdAddrBit] && acgCommand[primDataInBit]))
        else reportViolation("both primitives selected at once");

    startDecode: assert property (@(posedge iSystemClock) disable iff (!arstN)
        start == (cmdValid && opcode == readPageOpcode))
        else reportViolation("start does not match opcode and cmdValid");

    task automatic sendReadPage(input logic [numWays-1:0] ways,
                                input logic [colAddrWidth-1:0] col,
                                input logic [rowAddrWidth-1:0] row,
                                input logic [lengthWidth-1:0] len);
        logic                   done;
        int                     phaseIndex;
        logic [caWordWidth-1:0] expectedWord;
        logic [numWays-1:0]     expectedTarget;

        expectedTarget = ~ways;
        @(posedge iSystemClock);
        opcode <= readPageOpcode;
        cmdValid <= 1'b1;
        waySelect <= ways;
        colAddress <= col;
        rowAddress <= row;
        length <= len;
        @(negedge iSystemClock);
        compareValue("start", 1, start);
        compareValue("cmdReady before accept", 1, cmdReady);
        @(posedge iSystemClock);
        // inputs change after accept, the latched copy must hold
        cmdValid <= 1'b0;
        waySelect <= ~ways;
        colAddress <= ~col;
        rowAddress <= ~row;
        length <= ~len;
        @(negedge iSystemClock);
        compareValue("cmdReady after accept", 0, cmdReady);
        for (phaseIndex = 0; phaseIndex < 3; phaseIndex++) begin
            case (phaseIndex)
                0: expectedWord = {nandReadCmd1, 32'h0};
                1: expectedWord = addressWord(col, row);
                default: expectedWord = {nandReadCmd2, 32'h0};
            endcase
            do begin
                @(negedge iSystemClock);
                compareValue("acgCommand", 1 << primCmdAddrBit, acgCommand);
                compareValue("acgCaData", expectedWord, acgCaData);
                compareValue("acgCaSelect", phaseIndex != 1, acgCaSelect);
                compareValue("acgTargetWay", expectedTarget, acgTargetWay);
                if (phaseIndex == 1) begin
                    compareValue("acgNumOfData address", addrCycleCount, acgNumOfData);
                end
                done = acgLastStep[primCmdAddrBit];
            end while (!done);
        end
        // waiting on ready/busy
        do begin
            @(negedge iSystemClock);
            if (!transValid) begin
                compareValue("acgCommand while waiting", 0, acgCommand);
            end
        end while (!transValid);
        compareValue("ready/busy low then high before transValid", 1, busySeen && releaseSeen);
        do begin
            compareValue("acgCommand data", 1 << primDataInBit, acgCommand);
            compareValue("acgNumOfData data", len, acgNumOfData);
            compareValue("acgCaSelect data", 0, acgCaSelect);
            done = acgLastStep[primDataInBit];
            @(negedge iSystemClock);
            if (!done) begin
                compareValue("transValid again", 0, transValid);
            end
        end while (!done);
        compareValue("lastStep", 1, lastStep);
        compareValue("acgCommand after transfer", 0, acgCommand);
        compareValue("cmdReady with lastStep", 0, cmdReady);
        @(negedge iSystemClock);
        compareValue("lastStep after pulse", 0, lastStep);
        compareValue("cmdReady after transfer", 1, cmdReady);
    endtask

    initial begin : watchdog
        #(watchdogCycles * clockPeriod);
        $display("timeout: run did not finish within %0d cycles, stuck in test %s",
                 watchdogCycles, testName);
        $display("tests failed");
        $finish;
    end

    initial begin : stimulus
        int                 i;
        logic [numWays-1:0] ways;

        void'($urandom(32'h33f21fe4));
        iSystemClock = 1'b0;
        arstN = 1'b0;
        opcode = '0;
        cmdValid = 1'b0;
        waySelect = '0;
        colAddress = '0;
        rowAddress = '0;
        length = '0;
        errorCount = 0;
        testErrors = 0;
        cleanTests = 0;

        testName = "reset";
        repeat (resetCycles) @(posedge iSystemClock);
        arstN <= 1'b1;
        @(negedge iSystemClock);
        compareValue("cmdReady", 1, cmdReady);
        compareValue("lastStep", 0, lastStep);
        compareValue("transValid", 0, transValid);
        compareValue("acgCommand", 0, acgCommand);
        compareValue("acgCaSelect", 1, acgCaSelect);
        compareValue("acgCaData", 0, acgCaData);
        compareValue("acgNumOfData", 0, acgNumOfData);
        finishTest();

        testName = "wrongOpcode";
        @(posedge iSystemClock);
        opcode <= readPageOpcode + 6'($urandom_range(63, 1));
        cmdValid <= 1'b1;
        waySelect <= 4'($urandom_range(15, 1));
        repeat (4) begin
            @(negedge iSystemClock);
            compareValue("start", 0, start);
            compareValue("cmdReady", 1, cmdReady);
            compareValue("acgCommand", 0, acgCommand);
        end
        @(posedge iSystemClock);
        cmdValid <= 1'b0;
        opcode <= '0;
        finishTest();

        for (i = 0; i < commandCount; i++) begin
            testName = $sformatf("readPage%0d", i);
            // first command leaves ways unselected for the stray busy pulse
            ways = (i == 0) ? 4'b0010 : 4'($urandom_range(15, 1));
            sendReadPage(ways, 16'($urandom()), 24'($urandom()), 16'($urandom()));
            finishTest();
        end

        $display("%0d of %0d tests clean, %0d errors", cleanTests, testCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
